// File: word_cache_top.f
+incdir+source
source/cache_pkg.sv
source/block_memory.sv
source/cache_store.sv
source/cache_controller.sv
source/word_cache_top.sv
verification/cache_checker.sv
verification/word_cache_tb.sv

// File: Makefile
# Verilator build and run for the word cache testbench.

VERILATOR ?= verilator
TOP       ?= word_cache_tb
FILELIST  ?= word_cache_top.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0
PASS_TEXT ?= *** TEST PASSED ***

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"
	@echo "Variables: VERILATOR TOP FILELIST BUILD_DIR VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -qF '$(PASS_TEXT)'

clean:
	rm -rf $(BUILD_DIR)

// File: verification/cache_tests.txt
# op addr data hit; op R = read, W = write; addr and data in hex
# data is write data or expected read data; hit is checked for reads only
R 005 005 0
R 005 005 1
R 004 004 1
R 010 010 0
R 011 011 1
R 3FF 3FF 0
R 3FE 3FE 1
R 025 025 0
R 024 024 1
R 005 005 0
R 025 025 0
W 024 2A5 1
R 024 2A5 1
R 025 025 1
R 004 004 0
R 024 2A5 0
W 100 155 0
R 100 155 0
R 101 101 1
W 030 0AA 0
R 010 010 1
R 030 0AA 0
R 031 031 1
R 011 011 0
W 3FF 1C3 1
R 3FF 1C3 1
R 3FE 3FE 1
R 200 200 0
R 201 201 1
R 100 155 0
R 200 200 0
W 201 0F0 1
R 201 0F0 1
R 200 200 1
R 0C7 0C7 0
R 0C6 0C6 1
W 0C6 3A1 1
W 0C7 002 1
R 0C6 3A1 1
R 0C7 002 1
R 2C6 2C6 0
R 0C7 002 0
R 0C6 3A1 1
R 3FF 1C3 1
R 1E1 1E1 0
R 201 0F0 0

// File: verification/word_cache_tb.sv
`timescale 1ns/1ps

module word_cache_tb import cache_pkg::*;;

    localparam int HALF_PERIOD    = 50;
    localparam int RESET_CYCLES   = 3;
    localparam int SEED           = 7;
    localparam int CYCLES_PER_OP  = 20; // Watchdog budget per test line.
    localparam int EXTRA_CYCLES   = 50;
    localparam int MAX_GAP        = 3;

    logic  clk;
    logic  reset;
    logic  cpu_req;
    logic  cpu_we;
    addr_t cpu_addr;
    word_t cpu_wdata;
    logic  cpu_ready;
    logic  cpu_rvalid;
    word_t cpu_rdata;
    logic  cpu_hit;

    // Test lines as read from the data file.
    logic [7:0] op_q   [$];
    addr_t      addr_q [$];
    word_t      data_q [$];
    logic       hit_q  [$];

    int   n_tests     = 0;
    int   load_errors = 0;
    logic file_ok     = 1'b0;
    logic load_done   = 1'b0;
    int   total_errors;

    word_cache_top dut (
        .clk        (clk),
        .reset      (reset),
        .cpu_req    (cpu_req),
        .cpu_we     (cpu_we),
        .cpu_addr   (cpu_addr),
        .cpu_wdata  (cpu_wdata),
        .cpu_ready  (cpu_ready),
        .cpu_rvalid (cpu_rvalid),
        .cpu_rdata  (cpu_rdata),
        .cpu_hit    (cpu_hit)
    );

    cache_checker u_checker (
        .clk        (clk),
        .reset      (reset),
        .cpu_ready  (cpu_ready),
        .cpu_rvalid (cpu_rvalid),
        .cpu_rdata  (cpu_rdata),
        .cpu_hit    (cpu_hit)
    );

    always #(HALF_PERIOD) clk = ~clk;

    task automatic load_tests();
        int            fd;
        int            n;
        logic [8*80-1:0] text;
        logic [7:0]    op_c;
        addr_t         a_v;
        word_t         d_v;
        logic          h_v;
        fd = $fopen("verification/cache_tests.txt", "r");
        if (fd != 0) begin
            file_ok = 1'b1;
            while (!$feof(fd)) begin
                text = '0;
                if ($fgets(text, fd) == 0) break;
                op_c = 8'h00;
                n = $sscanf(text, "%s %h %h %h", op_c, a_v, d_v, h_v);
                if (n == 4 && (op_c == "R" || op_c == "W")) begin
                    op_q.push_back(op_c);
                    addr_q.push_back(a_v);
                    data_q.push_back(d_v);
                    hit_q.push_back(h_v);
                end else if (n > 0 && op_c != "#") begin
                    $display("Test file line could not be parsed: %0s", text);
                    load_errors++;
                end
            end
            $fclose(fd);
            n_tests   = op_q.size();
            load_done = 1'b1;
        end
    endtask

    // Waits until the DUT takes the request on a rising edge.
    task automatic wait_accept();
        @(negedge clk);
        while (!cpu_ready) @(negedge clk);
        @(posedge clk);
    endtask

    task automatic run_tests();
        int gap;
        for (int i = 0; i < n_tests; i++) begin
            gap = int'($urandom % (MAX_GAP + 1));
            if (gap != 0) begin
                cpu_req <= 1'b0;
                repeat (gap) @(posedge clk);
            end
            cpu_req   <= 1'b1;
            cpu_we    <= (op_q[i] == "W");
            cpu_addr  <= addr_q[i];
            cpu_wdata <= (op_q[i] == "W") ? data_q[i] : '0;
            if (op_q[i] == "R") begin
                u_checker.push_expect(data_q[i], hit_q[i]);
            end
            wait_accept();
        end
        cpu_req <= 1'b0;
        @(negedge clk);
        while (!cpu_ready) @(negedge clk); // Last operation done.
        repeat (2) @(negedge clk);
    endtask

    initial begin
        clk       = 1'b0;
        reset     = 1'b1;
        cpu_req   = 1'b0;
        cpu_we    = 1'b0;
        cpu_addr  = '0;
        cpu_wdata = '0;
        void'($urandom(SEED));
        load_tests();
        if (!file_ok) begin
            $display("Cannot open verification/cache_tests.txt");
            $display("*** TEST FAILED ***");
            $finish;
        end else begin
            repeat (RESET_CYCLES) @(posedge clk);
            reset <= 1'b0;
            @(posedge clk);
            run_tests();
            u_checker.check_drained();
            total_errors = u_checker.data_errors + u_checker.hit_errors +
                           u_checker.ready_errors + u_checker.other_errors + load_errors;
            $display("%0d lines, %0d reads; errors %0d data, %0d hit, %0d ready, %0d other",
                     n_tests, u_checker.reads_checked, u_checker.data_errors,
                     u_checker.hit_errors, u_checker.ready_errors,
                     u_checker.other_errors + load_errors);
            if (total_errors == 0) begin
                $display("*** TEST PASSED ***");
            end else begin
                $display("*** TEST FAILED ***");
            end
            $finish;
        end
    end

    // Watchdog sized from the number of test lines.
    initial begin
        wait (load_done);
        repeat (n_tests * CYCLES_PER_OP + EXTRA_CYCLES) @(posedge clk);
        $display("Timeout: the tests did not finish within %0d cycles",
                 n_tests * CYCLES_PER_OP + EXTRA_CYCLES);
        $display("*** TEST FAILED ***");
        $finish;
    end

endmodule

// File: verification/cache_checker.sv
`timescale 1ns/1ps

module cache_checker import cache_pkg::*; (
    input logic  clk,
    input logic  reset,
    input logic  cpu_ready,
    input logic  cpu_rvalid,
    input word_t cpu_rdata,
    input logic  cpu_hit
);

    // Expected read results in request order.
    word_t exp_data_q [$];
    logic  exp_hit_q  [$];

    int data_errors   = 0;
    int hit_errors    = 0;
    int ready_errors  = 0;
    int other_errors  = 0;
    int reads_checked = 0;

    task automatic push_expect(input word_t data, input logic hit);
        exp_data_q.push_back(data);
        exp_hit_q.push_back(hit);
    endtask

    // Read results are stable in the middle of the cycle.
    always @(negedge clk) begin
        word_t exp_data;
        logic  exp_hit;
        if (!reset && cpu_rvalid) begin
            if (exp_data_q.size() == 0) begin
                $display("Read data returned at %0t while no read was outstanding", $time);
                other_errors++;
            end else begin
                exp_data = exp_data_q.pop_front();
                exp_hit  = exp_hit_q.pop_front();
                reads_checked++;
                if (cpu_rdata !== exp_data) begin
                    $display("ERROR at %0t: cpu_rdata expected %h, actual %h",
                             $time, exp_data, cpu_rdata);
                    data_errors++;
                end
                if (cpu_hit !== exp_hit) begin
                    $display("ERROR at %0t: cpu_hit expected %b, actual %b",
                             $time, exp_hit, cpu_hit);
                    hit_errors++;
                end
                // A read hit frees the requester in its data cycle.
                if (exp_hit && cpu_ready !== 1'b1) begin
                    $display("ERROR at %0t: cpu_ready expected 1, actual %b",
                             $time, cpu_ready);
                    ready_errors++;
                end
            end
        end
    end

    // Called once all operations are done.
    task automatic check_drained();
        if (exp_data_q.size() != 0) begin
            $display("%0d expected reads never returned data", exp_data_q.size());
            other_errors += exp_data_q.size();
        end
    endtask

endmodule

// File: source/word_cache_top.sv
`timescale 1ns/1ps

module word_cache_top import cache_pkg::*; (
    input  logic  clk,
    input  logic  reset,
    input  logic  cpu_req,
    input  logic  cpu_we,
    input  addr_t cpu_addr,
    input  word_t cpu_wdata,
    output logic  cpu_ready,
    output logic  cpu_rvalid,
    output word_t cpu_rdata,
    output logic  cpu_hit
);

    // Controller to store.
    addr_t  lookup_addr;
    logic   hit;
    word_t  read_word;
    logic   fill_en;
    block_t fill_block;
    logic   write_en;
    word_t  write_word;

    // Controller to memory.
    logic   mem_req;
    logic   mem_we;
    addr_t  mem_addr;
    word_t  mem_wdata;
    logic   mem_ready;
    block_t mem_rdata;

    cache_controller u_controller (
        .clk         (clk),
        .reset       (reset),
        .cpu_req     (cpu_req),
        .cpu_we      (cpu_we),
        .cpu_addr    (cpu_addr),
        .cpu_wdata   (cpu_wdata),
        .cpu_ready   (cpu_ready),
        .cpu_rvalid  (cpu_rvalid),
        .cpu_rdata   (cpu_rdata),
        .cpu_hit     (cpu_hit),
        .lookup_addr (lookup_addr),
        .hit         (hit),
        .read_word   (read_word),
        .fill_en     (fill_en),
        .fill_block  (fill_block),
        .write_en    (write_en),
        .write_word  (write_word),
        .mem_req     (mem_req),
        .mem_we      (mem_we),
        .mem_addr    (mem_addr),
        .mem_wdata   (mem_wdata),
        .mem_ready   (mem_ready),
        .mem_rdata   (mem_rdata)
    );

    cache_store u_store (
        .clk         (clk),
        .reset       (reset),
        .lookup_addr (lookup_addr),
        .fill_en     (fill_en),
        .fill_block  (fill_block),
        .write_en    (write_en),
        .write_word  (write_word),
        .hit         (hit),
        .read_word   (read_word)
    );

    block_memory u_memory (
        .clk       (clk),
        .reset     (reset),
        .mem_req   (mem_req),
        .mem_we    (mem_we),
        .mem_addr  (mem_addr),
        .mem_wdata (mem_wdata),
        .mem_ready (mem_ready),
        .mem_rdata (mem_rdata)
    );

endmodule

// File: source/cache_controller.sv
`timescale 1ns/1ps

module cache_controller import cache_pkg::*; (
    input  logic   clk,
    input  logic   reset,

    // Requester side.
    input  logic   cpu_req,
    input  logic   cpu_we,
    input  addr_t  cpu_addr,
    input  word_t  cpu_wdata,
    output logic   cpu_ready,
    output logic   cpu_rvalid,
    output word_t  cpu_rdata,
    output logic   cpu_hit,

    // Cache store.
    output addr_t  lookup_addr,
    input  logic   hit,
    input  word_t  read_word,
    output logic   fill_en,
    output block_t fill_block,
    output logic   write_en,
    output word_t  write_word,

    // Backing memory.
    output logic   mem_req,
    output logic   mem_we,
    output addr_t  mem_addr,
    output word_t  mem_wdata,
    input  logic   mem_ready,
    input  block_t mem_rdata
);

    ctrl_state_t state;

    logic  pend;    // Request accepted on the last edge and looked up in this cycle.
    logic  issued;  // Memory request sent and waiting for ready.
    logic  accept;
    logic  mem_done;

    logic  req_we;
    addr_t req_addr;
    word_t req_wdata;

    assign accept   = cpu_req && cpu_ready;
    assign mem_done = issued && mem_ready;

    // Only a read hit finishes in the lookup cycle.
    assign cpu_ready = (state == st_idle) && !(pend && (req_we || !hit));

    assign cpu_rvalid = ((state == st_idle) && pend && !req_we && hit) ||
                        ((state == st_fetch) && mem_done);
    assign cpu_rdata  = (state == st_fetch) ? mem_rdata[addr_offset(req_addr)] : read_word;
    assign cpu_hit    = (state == st_idle) && hit;

    assign lookup_addr = req_addr;
    assign fill_en     = (state == st_fetch) && mem_done;
    assign fill_block  = mem_rdata;
    assign write_en    = (state == st_idle) && pend && req_we; // Store ignores it on a miss.
    assign write_word  = req_wdata;

    // The memory request lasts one cycle and waits for a free memory.
    assign mem_req   = ((state == st_fetch) || (state == st_write_mem)) && !issued && mem_ready;
    assign mem_we    = (state == st_write_mem);
    assign mem_addr  = req_addr;
    assign mem_wdata = req_wdata;

    always_ff @(posedge clk) begin
        if (reset) begin
            state    <= st_idle;
            pend     <= 1'b0;
            issued   <= 1'b0;
            req_we   <= 1'b0;
            req_addr <= '0;
        end else begin
            pend <= accept;
            if (accept) begin
                req_we   <= cpu_we;
                req_addr <= cpu_addr;
            end

            if (mem_req) begin
                issued <= 1'b1;
            end else if (mem_done) begin
                issued <= 1'b0;
            end

            case (state)
                st_idle: begin
                    if (pend && req_we) begin
                        state <= st_write_mem; // Write-through on hit and miss.
                    end else if (pend && !hit) begin
                        state <= st_fetch;
                    end
                end
                st_fetch, st_write_mem: begin
                    if (mem_done) begin
                        state <= st_idle;
                    end
                end
                default: state <= st_idle;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            req_wdata <= cpu_wdata;
        end
    end

    // A request taken by the memory drops ready on the next cycle.
    assert property (@(posedge clk) disable iff (reset) mem_req |=> !mem_ready)
        else $error("cache_controller: memory did not take the request");

endmodule

// File: source/cache_store.sv
`timescale 1ns/1ps
`include "cache_settings.svh"

module cache_store import cache_pkg::*; (
    input  logic   clk,
    input  logic   reset,
    input  addr_t  lookup_addr,
    input  logic   fill_en,
    input  block_t fill_block,
    input  logic   write_en,
    input  word_t  write_word,
    output logic   hit,
    output word_t  read_word
);

    logic [`CACHE_LINES-1:0] valid_bits;
    tag_t                    tag_array  [0:`CACHE_LINES-1];
    block_t                  data_array [0:`CACHE_LINES-1];

    index_t line;
    tag_t   tag;
    logic   offset;

    assign line   = addr_index(lookup_addr);
    assign tag    = addr_tag(lookup_addr);
    assign offset = addr_offset(lookup_addr);

    // Lookup is purely combinational.
    assign hit       = valid_bits[line] && (tag_array[line] == tag);
    assign read_word = data_array[line][offset];

    always_ff @(posedge clk) begin
        if (reset) begin
            valid_bits <= '0;
        end else if (fill_en) begin
            valid_bits[line] <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (fill_en) begin
            tag_array[line]  <= tag;
            data_array[line] <= fill_block; // Whole block, evicting the old line.
        end else if (write_en && hit) begin
            data_array[line][offset] <= write_word; // Write miss leaves the line alone.
        end
    end

    // Fill belongs to a read miss, word update to a write.
    assert property (@(posedge clk) disable iff (reset) !(fill_en && write_en))
        else $error("cache_store: fill and write in the same cycle");

    // The controller holds the address after a fill, so the line must hit.
    assert property (@(posedge clk) disable iff (reset) fill_en |=> hit)
        else $error("cache_store: no hit after line fill");

endmodule

// File: source/block_memory.sv
`timescale 1ns/1ps
`include "cache_settings.svh"

module block_memory import cache_pkg::*; (
    input  logic   clk,
    input  logic   reset,
    input  logic   mem_req,
    input  logic   mem_we,
    input  addr_t  mem_addr,
    input  word_t  mem_wdata,
    output logic   mem_ready,
    output block_t mem_rdata
);

    typedef enum logic [1:0] {
        mem_idle,
        mem_wait,
        mem_execute
    } mem_state_t;

    mem_state_t state;
    logic [3:0] wait_cnt;
    logic       accept;

    // Request latched at accept.
    logic  lat_we;
    addr_t lat_addr;
    word_t lat_wdata;

    word_t mem_array [0:`MEM_WORDS-1];

    // Every word starts out holding its own address.
    initial begin
        for (int i = 0; i < `MEM_WORDS; i++) begin
            mem_array[i] = word_t'(i);
        end
    end

    assign accept = mem_req && (state == mem_idle);

    always_ff @(posedge clk) begin
        if (reset) begin
            state     <= mem_idle;
            mem_ready <= 1'b1;
            wait_cnt  <= '0;
        end else begin
            case (state)
                mem_idle: begin
                    if (accept) begin
                        state     <= mem_wait;
                        mem_ready <= 1'b0;
                        wait_cnt  <= 4'(`MEM_LATENCY - 2); // Execute takes the last cycle.
                    end
                end
                mem_wait: begin
                    if (wait_cnt == '0) begin
                        state <= mem_execute;
                    end else begin
                        wait_cnt <= wait_cnt - 1'b1;
                    end
                end
                mem_execute: begin
                    state     <= mem_idle;
                    mem_ready <= 1'b1; // Result is visible as ready returns.
                end
                default: begin
                    state     <= mem_idle;
                    mem_ready <= 1'b1;
                end
            endcase
        end
    end

    always @(posedge clk) begin
        if (accept) begin
            lat_we    <= mem_we;
            lat_addr  <= mem_addr;
            lat_wdata <= mem_wdata;
        end
        if (state == mem_execute) begin
            if (lat_we) begin
                mem_array[lat_addr] <= lat_wdata;
            end else begin
                // Aligned even/odd pair of the block.
                mem_rdata[1] <= mem_array[{lat_addr[`ADDR_WIDTH-1:1], 1'b1}];
                mem_rdata[0] <= mem_array[{lat_addr[`ADDR_WIDTH-1:1], 1'b0}];
            end
        end
    end

    // The requester side may only ask while the memory is free.
    assert property (@(posedge clk) disable iff (reset) mem_req |-> mem_ready)
        else $error("block_memory: mem_req while mem_ready is low");

endmodule

// File: source/cache_pkg.sv
`include "cache_settings.svh"

package cache_pkg;

    typedef logic [`ADDR_WIDTH-1:0]  addr_t;
    typedef logic [`WORD_WIDTH-1:0]  word_t;
    typedef logic [`TAG_WIDTH-1:0]   tag_t;
    typedef logic [`INDEX_WIDTH-1:0] index_t;

    // Element 1 is the odd address, element 0 the even one.
    typedef word_t [1:0] block_t;

    typedef enum logic [1:0] {
        st_idle,      // Waiting for a request or doing the lookup.
        st_fetch,     // Read miss, block fetch from memory.
        st_write_mem  // Write-through to memory.
    } ctrl_state_t;

    // Address field extraction.
    function automatic tag_t addr_tag(addr_t addr);
        return addr[`ADDR_WIDTH-1:`INDEX_WIDTH+1];
    endfunction

    function automatic index_t addr_index(addr_t addr);
        return addr[`INDEX_WIDTH:1];
    endfunction

    function automatic logic addr_offset(addr_t addr);
        return addr[0];
    endfunction

endpackage

// File: source/cache_settings.svh
`ifndef CACHE_SETTINGS_SVH
`define CACHE_SETTINGS_SVH

// Word address and data widths.
`define ADDR_WIDTH 10
`define WORD_WIDTH 10

// Direct-mapped geometry: one two-word block per line.
`define INDEX_WIDTH 4
`define CACHE_LINES (1 << `INDEX_WIDTH)
`define TAG_WIDTH (`ADDR_WIDTH - `INDEX_WIDTH - 1)

// Backing memory size in words.
`define MEM_WORDS (1 << `ADDR_WIDTH)

// Cycles mem_ready stays low after an accepted request.
`define MEM_LATENCY 2

`endif
